// ==== src/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;

    localparam logic [ID_W-1:0] INST_ID = 4'd0; // Instruction fetch
    localparam logic [ID_W-1:0] DATA_ID = 4'd1; // Loads and stores

    // Bytes per beat, log2 encoded
    typedef logic [2:0] size_t;
    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        size_t             size;
    } load_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } store_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } rd_rsp_t;

    typedef struct packed {
        resp_t resp;
    } wr_rsp_t;

    // Also used for aw
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        size_t             size;
    } ar_chan_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } r_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
    } w_chan_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_t           resp;
    } b_chan_t;

endpackage

// ==== src/read_arbiter.sv ====
`timescale 1ns/1ns

module read_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_bus_pkg::fetch_req_t fetch_req,
    input  logic                    fetch_req_valid,
    output logic                    fetch_req_ready,
    input  cpu_bus_pkg::load_req_t  load_req,
    input  logic                    load_req_valid,
    output logic                    load_req_ready,
    output cpu_bus_pkg::ar_chan_t   ar,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    input  logic                    retire_inst,
    input  logic                    retire_data
);
    import cpu_bus_pkg::*;

    logic inst_busy;
    logic data_busy;
    logic load_take;
    logic fetch_take;
    logic ar_fire;

    // One ar slot, one outstanding read per ID
    assign load_req_ready  = !ar_valid && !data_busy;
    assign load_take       = load_req_valid && load_req_ready;
    assign fetch_req_ready = !ar_valid && !inst_busy && !load_take; // Load wins
    assign fetch_take      = fetch_req_valid && fetch_req_ready;
    assign ar_fire         = ar_valid && ar_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
        end else if (load_take || fetch_take) begin
            ar_valid <= 1'b1;
        end else if (ar_ready) begin
            ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_take) begin
            ar.id   <= DATA_ID;
            ar.addr <= load_req.addr;
            ar.size <= load_req.size;
        end else if (fetch_take) begin
            ar.id   <= INST_ID;
            ar.addr <= {fetch_req.addr[ADDR_W-1:2], 2'b00}; // Word aligned
            ar.size <= SIZE_WORD;
        end
    end

    // Outstanding from ar handshake until the r beat retires
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (retire_inst) begin
                inst_busy <= 1'b0;
            end
            if (retire_data) begin
                data_busy <= 1'b0;
            end
            if (ar_fire && ar.id == INST_ID) begin
                inst_busy <= 1'b1;
            end
            if (ar_fire && ar.id == DATA_ID) begin
                data_busy <= 1'b1;
            end
        end
    end

endmodule

// ==== src/read_response_router.sv ====
`timescale 1ns/1ns

module read_response_router (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_bus_pkg::r_chan_t r,
    input  logic                 r_valid,
    output logic                 r_ready,
    output cpu_bus_pkg::rd_rsp_t fetch_rsp,
    output logic                 fetch_rsp_valid,
    input  logic                 fetch_rsp_ready,
    output cpu_bus_pkg::rd_rsp_t load_rsp,
    output logic                 load_rsp_valid,
    input  logic                 load_rsp_ready,
    output logic                 retire_inst,
    output logic                 retire_data
);
    import cpu_bus_pkg::*;

    // Slot 0 holds fetch replies, slot 1 load replies
    rd_rsp_t    buf_q [2];
    logic [1:0] buf_valid;
    logic [1:0] hit;
    logic [1:0] pop;
    logic [1:0] room;
    logic [1:0] take;

    assign hit[0]  = (r.id == INST_ID);
    assign hit[1]  = (r.id == DATA_ID);
    assign pop     = {load_rsp_ready, fetch_rsp_ready};
    assign room    = ~buf_valid | pop; // Empty or draining this cycle
    assign r_ready = r_valid && |(hit & room);
    assign take    = {2{r_valid && r_ready}} & hit;

    assign retire_inst = take[0];
    assign retire_data = take[1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (take[i]) begin
                buf_q[i].data <= r.data;
                buf_q[i].resp <= r.resp;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 2'b00;
        end else begin
            buf_valid <= take | (buf_valid & ~pop);
        end
    end

    assign fetch_rsp       = buf_q[0];
    assign fetch_rsp_valid = buf_valid[0];
    assign load_rsp        = buf_q[1];
    assign load_rsp_valid  = buf_valid[1];

endmodule

// ==== src/write_channel.sv ====
`timescale 1ns/1ns

module write_channel (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_bus_pkg::store_req_t store_req,
    input  logic                    store_req_valid,
    output logic                    store_req_ready,
    output cpu_bus_pkg::ar_chan_t   aw,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output cpu_bus_pkg::w_chan_t    w,
    output logic                    w_valid,
    input  logic                    w_ready,
    input  cpu_bus_pkg::b_chan_t    b,
    input  logic                    b_valid,
    output logic                    b_ready,
    output cpu_bus_pkg::wr_rsp_t    store_rsp,
    output logic                    store_rsp_valid,
    input  logic                    store_rsp_ready
);
    import cpu_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,   // aw and w in flight
        ST_WAIT_B,
        ST_RSP
    } state_t;

    state_t state;
    logic   accept;
    logic   aw_done;
    logic   w_done;

    assign store_req_ready = (state == ST_IDLE);
    assign accept          = store_req_valid && store_req_ready;
    assign aw_done         = !aw_valid || aw_ready;
    assign w_done          = !w_valid || w_ready;
    assign b_ready         = (state == ST_WAIT_B);
    assign store_rsp_valid = (state == ST_RSP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state    <= ST_SEND;
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                    end
                end
                ST_SEND: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= ST_WAIT_B;
                    end
                end
                ST_WAIT_B: begin
                    if (b_valid) begin
                        state <= ST_RSP;
                    end
                end
                default: begin
                    if (store_rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aw.id   <= DATA_ID;
            aw.addr <= store_req.addr;
            aw.size <= SIZE_WORD;
            w.data  <= store_req.data;
            w.strb  <= store_req.strb; // Byte lanes select the store width
        end
        if (b_valid && b_ready) begin
            store_rsp.resp <= b.resp;
        end
    end

endmodule

// ==== src/cpu_bus_bridge.sv ====
`timescale 1ns/1ns

module cpu_bus_bridge (
    input  logic                    clk,
    input  logic                    rst,
    input  cpu_bus_pkg::fetch_req_t fetch_req,
    input  logic                    fetch_req_valid,
    output logic                    fetch_req_ready,
    output cpu_bus_pkg::rd_rsp_t    fetch_rsp,
    output logic                    fetch_rsp_valid,
    input  logic                    fetch_rsp_ready,
    input  cpu_bus_pkg::load_req_t  load_req,
    input  logic                    load_req_valid,
    output logic                    load_req_ready,
    output cpu_bus_pkg::rd_rsp_t    load_rsp,
    output logic                    load_rsp_valid,
    input  logic                    load_rsp_ready,
    input  cpu_bus_pkg::store_req_t store_req,
    input  logic                    store_req_valid,
    output logic                    store_req_ready,
    output cpu_bus_pkg::wr_rsp_t    store_rsp,
    output logic                    store_rsp_valid,
    input  logic                    store_rsp_ready,
    output cpu_bus_pkg::ar_chan_t   ar,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    input  cpu_bus_pkg::r_chan_t    r,
    input  logic                    r_valid,
    output logic                    r_ready,
    output cpu_bus_pkg::ar_chan_t   aw,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output cpu_bus_pkg::w_chan_t    w,
    output logic                    w_valid,
    input  logic                    w_ready,
    input  cpu_bus_pkg::b_chan_t    b,
    input  logic                    b_valid,
    output logic                    b_ready
);

    logic retire_inst; // Frees the fetch ID
    logic retire_data;

    read_arbiter u_read_arbiter (
        .clk             (clk),
        .rst             (rst),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .load_req        (load_req),
        .load_req_valid  (load_req_valid),
        .load_req_ready  (load_req_ready),
        .ar              (ar),
        .ar_valid        (ar_valid),
        .ar_ready        (ar_ready),
        .retire_inst     (retire_inst),
        .retire_data     (retire_data)
    );

    read_response_router u_read_response_router (
        .clk             (clk),
        .rst             (rst),
        .r               (r),
        .r_valid         (r_valid),
        .r_ready         (r_ready),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_ready (fetch_rsp_ready),
        .load_rsp        (load_rsp),
        .load_rsp_valid  (load_rsp_valid),
        .load_rsp_ready  (load_rsp_ready),
        .retire_inst     (retire_inst),
        .retire_data     (retire_data)
    );

    write_channel u_write_channel (
        .clk             (clk),
        .rst             (rst),
        .store_req       (store_req),
        .store_req_valid (store_req_valid),
        .store_req_ready (store_req_ready),
        .aw              (aw),
        .aw_valid        (aw_valid),
        .aw_ready        (aw_ready),
        .w               (w),
        .w_valid         (w_valid),
        .w_ready         (w_ready),
        .b               (b),
        .b_valid         (b_valid),
        .b_ready         (b_ready),
        .store_rsp       (store_rsp),
        .store_rsp_valid (store_rsp_valid),
        .store_rsp_ready (store_rsp_ready)
    );

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model #(
    parameter int          DEPTH     = 256,
    parameter logic [31:0] ERR_LIMIT = 32'h400,
    parameter logic [31:0] PATTERN   = 32'h5a3c_96e1,
    parameter logic [15:0] SEED      = 16'd60
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::ar_chan_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output cpu_bus_pkg::r_chan_t  r,
    output logic                  r_valid,
    input  logic                  r_ready,
    input  cpu_bus_pkg::ar_chan_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  cpu_bus_pkg::w_chan_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output cpu_bus_pkg::b_chan_t  b,
    output logic                  b_valid,
    input  logic                  b_ready
);
    import cpu_bus_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [15:0]       lfsr;
    logic [1:0]        pend;                 // One slot per ID
    logic [ADDR_W-1:0] paddr [2];
    logic [1:0]        delay [2];
    logic              aw_got;
    logic              w_got;
    logic [ADDR_W-1:0] waddr;
    w_chan_t           wbuf;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    initial begin
        r_valid = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (i * 4) ^ PATTERN;
        end
    end

    assign ar_ready = !rst;
    assign aw_ready = !rst;

    always @(posedge clk) begin : model
        logic [15:0] s;
        logic [1:0]  d;
        logic        rdy0;
        logic        rdy1;
        int          pick;
        if (rst) begin
            lfsr    <= SEED;
            pend    <= 2'b00;
            r_valid <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            s = lfsr;
            if (ar_valid && ar_ready) begin
                d[0] = s[0];
                s = lfsr_next(s);
                d[1] = s[0];
                s = lfsr_next(s);
                pend[ar.id[0]]  <= 1'b1;
                paddr[ar.id[0]] <= ar.addr;
                delay[ar.id[0]] <= d; // 0 to 3 cycles before reply
            end
            for (int i = 0; i < 2; i++) begin
                if (pend[i] && delay[i] != 2'd0) begin
                    delay[i] <= delay[i] - 2'd1;
                end
            end
            rdy0 = pend[0] && delay[0] == 2'd0;
            rdy1 = pend[1] && delay[1] == 2'd0;
            if (r_valid && r_ready) begin
                r_valid        <= 1'b0;
                pend[r.id[0]]  <= 1'b0;
            end else if (!r_valid && (rdy0 || rdy1)) begin
                if (rdy0 && rdy1) begin
                    pick = int'(s[0]); // Either order
                    s = lfsr_next(s);
                end else begin
                    pick = int'(rdy1);
                end
                r_valid <= 1'b1;
                r.id    <= ID_W'(pick);
                if (paddr[pick] >= ERR_LIMIT) begin
                    r.data <= '0;
                    r.resp <= RESP_SLVERR;
                end else begin
                    r.data <= mem[paddr[pick][9:2]];
                    r.resp <= RESP_OKAY;
                end
            end
            w_ready <= s[0];
            s = lfsr_next(s);
            if (aw_valid && aw_ready) begin
                aw_got <= 1'b1;
                waddr  <= aw.addr;
            end
            if (w_valid && w_ready) begin
                w_got <= 1'b1;
                wbuf  <= w;
            end
            if (aw_got && w_got && !b_valid) begin
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_valid <= 1'b1;
                b.id    <= DATA_ID;
                b.resp  <= (waddr >= ERR_LIMIT) ? RESP_SLVERR : RESP_OKAY;
                if (waddr < ERR_LIMIT) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wbuf.strb[k]) begin
                            mem[waddr[9:2]][8*k +: 8] <= wbuf.data[8*k +: 8];
                        end
                    end
                end
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            lfsr <= s;
        end
    end

endmodule

// ==== verif/tb_cpu_bus_bridge.sv ====
`timescale 1ns/1ns

module tb_cpu_bus_bridge;
    import cpu_bus_pkg::*;

    localparam int          DEPTH     = 256;
    localparam logic [31:0] ERR_LIMIT = 32'h400;
    localparam logic [31:0] PATTERN   = 32'h5a3c_96e1;

    logic clk = 1'b0;
    logic rst = 1'b1;
    fetch_req_t fetch_req = '0;
    logic fetch_req_valid = 1'b0;
    logic fetch_req_ready;
    rd_rsp_t fetch_rsp;
    logic fetch_rsp_valid;
    logic fetch_rsp_ready = 1'b1;
    load_req_t load_req = '0;
    logic load_req_valid = 1'b0;
    logic load_req_ready;
    rd_rsp_t load_rsp;
    logic load_rsp_valid;
    logic load_rsp_ready = 1'b1;
    store_req_t store_req = '0;
    logic store_req_valid = 1'b0;
    logic store_req_ready;
    wr_rsp_t store_rsp;
    logic store_rsp_valid;
    logic store_rsp_ready = 1'b1;
    ar_chan_t ar;
    ar_chan_t aw;
    r_chan_t r;
    w_chan_t w;
    b_chan_t b;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;
    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;

    logic [DATA_W-1:0] shadow [DEPTH];
    rd_rsp_t    exp_fetch [$];
    rd_rsp_t    exp_load [$];
    resp_t      exp_store [$];
    ar_chan_t   exp_ar_inst [$];
    ar_chan_t   exp_ar_data [$];
    ar_chan_t   exp_aw [$];
    w_chan_t    exp_w [$];
    logic [3:0] ar_log [$];
    int issued = 0;
    int cycles = 0;
    int stall_seen = 0;

    cpu_bus_bridge uut (.*);

    axi_mem_model #(.DEPTH(DEPTH), .ERR_LIMIT(ERR_LIMIT), .PATTERN(PATTERN), .SEED(16'd60))
        u_mem (.*);

    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // Expected read reply from the shadow memory
    function automatic rd_rsp_t ref_read(input logic [31:0] addr);
        rd_rsp_t rsp;
        if (addr >= ERR_LIMIT) begin
            rsp.data = '0;
            rsp.resp = RESP_SLVERR;
        end else begin
            rsp.data = shadow[addr[9:2]];
            rsp.resp = RESP_OKAY;
        end
        return rsp;
    endfunction

    task automatic send_fetch(input logic [31:0] a);
        exp_ar_inst.push_back({INST_ID, a[31:2], 2'b00, SIZE_WORD});
        exp_fetch.push_back(ref_read(a));
        issued++;
        fetch_req.addr  = a;
        fetch_req_valid = 1'b1;
        @(posedge clk);
        while (!fetch_req_ready) @(posedge clk);
        #1 fetch_req_valid = 1'b0;
    endtask

    task automatic send_load(input logic [31:0] a, input size_t sz);
        exp_ar_data.push_back({DATA_ID, a, sz});
        exp_load.push_back(ref_read(a));
        issued++;
        load_req.addr  = a;
        load_req.size  = sz;
        load_req_valid = 1'b1;
        @(posedge clk);
        while (!load_req_ready) @(posedge clk);
        #1 load_req_valid = 1'b0;
    endtask

    task automatic send_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        exp_store.push_back(a >= ERR_LIMIT ? RESP_SLVERR : RESP_OKAY);
        exp_aw.push_back({DATA_ID, a, SIZE_WORD});
        exp_w.push_back({d, s});
        issued++;
        if (a < ERR_LIMIT) begin
            for (int k = 0; k < 4; k++) begin
                if (s[k]) shadow[a[9:2]][8*k +: 8] = d[8*k +: 8];
            end
        end
        store_req       = '{addr: a, data: d, strb: s};
        store_req_valid = 1'b1;
        @(posedge clk);
        while (!store_req_ready) @(posedge clk);
        #1 store_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_fetch.size() + exp_load.size() + exp_store.size() != 0) @(posedge clk);
        #1;
    endtask

    // Compare process
    always @(posedge clk) begin : compare
        ar_chan_t exp_ar;
        if (!rst) begin
            if (ar_valid && ar_ready) begin
                ar_log.push_back(ar.id);
                if (ar.id == INST_ID && exp_ar_inst.size() != 0) begin
                    exp_ar = exp_ar_inst.pop_front();
                end else if (ar.id == DATA_ID && exp_ar_data.size() != 0) begin
                    exp_ar = exp_ar_data.pop_front();
                end else begin
                    report_failure("ar request with no matching CPU request");
                end
                check("ar", exp_ar, ar);
            end
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0) report_failure("aw request with no matching store");
                check("aw", exp_aw.pop_front(), aw);
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) report_failure("w beat with no matching store");
                check("w", exp_w.pop_front(), w);
            end
            if (fetch_rsp_valid && fetch_rsp_ready) begin
                if (exp_fetch.size() == 0) report_failure("fetch reply that was never requested");
                check("fetch_rsp", exp_fetch.pop_front(), fetch_rsp);
            end
            if (load_rsp_valid && load_rsp_ready) begin
                if (exp_load.size() == 0) report_failure("load reply that was never requested");
                check("load_rsp", exp_load.pop_front(), load_rsp);
            end
            if (store_rsp_valid && store_rsp_ready) begin
                if (exp_store.size() == 0) report_failure("store reply that was never requested");
                check("store_rsp", exp_store.pop_front(), store_rsp);
            end
            if (r_valid && r.id == DATA_ID && load_rsp_valid && !load_rsp_ready) begin
                stall_seen++;
                check("r_ready", 0, r_ready);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * issued + 200) begin
            $display("Timeout after %0d cycles with %0d transactions", cycles, issued);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        for (int i = 0; i < DEPTH; i++) shadow[i] = (i * 4) ^ PATTERN;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < 6; i++) send_fetch(i * 12 + i % 4); // Unaligned too
        wait_idle();
        send_load(32'h41, SIZE_BYTE);
        send_load(32'h82, SIZE_HALF);
        send_load(32'h0c4, SIZE_WORD);
        wait_idle();
        for (int i = 0; i < 8; i++) begin
            ar_log.delete();
            fork
                send_fetch(32'h100 + i * 4);
                send_load(32'h200 + i * 8, SIZE_WORD);
            join
            wait_idle();
            check("first_ar_id", DATA_ID, ar_log[0]);
        end
        send_store(32'h48, 32'hdead_beef, 4'b0110);
        wait_idle(); // Read and write channels are not ordered
        send_load(32'h48, SIZE_WORD);
        send_store(32'h4c, 32'h1234_5678, 4'b1111);
        wait_idle();
        send_load(32'h4c, SIZE_WORD);
        wait_idle();
        send_fetch(32'h404);
        send_load(32'h800, SIZE_WORD);
        send_store(32'h1000, 32'h0, 4'b1111);
        wait_idle();
        load_rsp_ready = 1'b0; // First load sits in the buffer
        send_load(32'h30, SIZE_WORD);
        send_fetch(32'h34);
        while (exp_fetch.size() != 0) @(posedge clk);
        send_load(32'h38, SIZE_WORD);
        while (stall_seen < 3) @(posedge clk);
        #1 load_rsp_ready = 1'b1;
        wait_idle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
src/cpu_bus_pkg.sv
src/read_arbiter.sv
src/read_response_router.sv
src/write_channel.sv
src/cpu_bus_bridge.sv
verif/axi_mem_model.sv
verif/tb_cpu_bus_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_bus_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
